//--- Makefile
SIM := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP := tbGpuFrontEnd
FILELIST := verilog.f
OBJDIR := obj_dir
PASSMSG := >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qxF -- '$(PASSMSG)'

clean:
	rm -rf $(OBJDIR)

//--- sim/clkGen.sv
`timescale 1ns/10ps
`default_nettype none

module clkGen #(
	parameter int Period = 20,
	parameter int ResetCycles = 8
) (
	output logic clk,
	output logic arstN
);

	initial begin
		clk = 1'b0;
		forever #(Period / 2) clk = ~clk;
	end

	initial begin
		arstN = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		#2 arstN = 1'b1; // Released off the edge like other inputs
	end

endmodule

`default_nettype wire

//--- sim/frontEndGolden.txt
// Header: single-warp launch mask, all-warp launch mask, relaunch mask, stall percent
// Rows, one per PC: instruction word, aluOp, dst, flags (src1V src2V immV wr mrd mwr shr beq blt exit noop)
00000001 000000FF 00000010 00000028
00221820 0 03 680 // 0x00 add
00222022 1 04 680 // 0x04 sub
00642818 2 05 680 // 0x08 mul
00223024 3 06 680 // 0x0c and
00223825 4 07 680 // 0x10 or
00224026 5 08 680 // 0x14 xor
00204882 6 09 680 // 0x18 shr
002050C0 7 0A 680 // 0x1c shl
202B0004 0 0B 580 // 0x20 addi
302C00FF 3 0C 580 // 0x24 andi
342D0F04 4 0D 580 // 0x28 ori
382E1234 5 0E 580 // 0x2c xori
0C000010 0 00 000 // 0x30 call 0x40
04000000 7 00 001 // 0x34 skipped
04000000 7 00 001 // 0x38 skipped
04000000 7 00 001 // 0x3c skipped
8C4F0008 0 0F 4C0 // 0x40 ld
9C50000C 0 10 4D0 // 0x44 lds
AC430010 0 00 620 // 0x48 sw
BC440014 0 00 630 // 0x4c sws
10220024 3 00 608 // 0x50 beq, funct bits decode as and
1C220808 0 01 604 // 0x54 blt
0800001A 0 00 000 // 0x58 j 0x68
04000000 7 00 001 // 0x5c skipped
04000000 7 00 001 // 0x60 skipped
04000000 7 00 001 // 0x64 skipped
18000000 7 00 000 // 0x68 ret
04000000 7 00 001 // 0x6c noop
84000000 7 00 002 // 0x70 exit

//--- sim/tbGpuFrontEnd.sv
`timescale 1ns/10ps
`default_nettype none

module tbGpuFrontEnd import gpuPkg::*; ();

	localparam int ProgWords = 29;
	localparam int GoldenLen = 4 + 4 * ProgWords;
	localparam int Seed = 25529;
	localparam int WaitLimit = 200;
	localparam int RunLimit = 4000;

	logic clk;
	logic arstN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [11:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic issueReady;
	logic issueValid;
	warpMaskT issueWarp;
	logic [31:0] issuePc;
	logic [3:0] issueAluOp;
	logic [4:0] issueSrc1;
	logic [4:0] issueSrc2;
	logic [4:0] issueDst;
	logic [15:0] issueImme;
	logic [10:0] issueFlags;

	logic [31:0] golden [GoldenLen]; // Header then four words per PC
	logic [31:0] modelPc [NumWarps];
	int issued [NumWarps];
	warpMaskT launched;
	warpMaskT exited;
	logic stallOn;
	int traceLen;
	int errors;
	int timeouts;

	clkGen #(
		.Period(20),
		.ResetCycles(8)
	) u_clkGen (
		.clk(clk),
		.arstN(arstN)
	);

	gpuFrontEnd #(
		.ImemDepth(64)
	) u_gpuFrontEnd (
		.clk(clk),
		.arstN(arstN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.issueReady(issueReady),
		.issueValid(issueValid),
		.issueWarp(issueWarp),
		.issuePc(issuePc),
		.issueAluOp(issueAluOp),
		.issueSrc1(issueSrc1),
		.issueSrc2(issueSrc2),
		.issueDst(issueDst),
		.issueImme(issueImme),
		.issueFlags(issueFlags)
	);

	function automatic int rowIdx(input logic [31:0] pc);
		return 4 + 4 * int'(pc >> 2);
	endfunction

	// J and CALL take the word target, all else falls through
	function automatic logic [31:0] nextPc(input logic [31:0] pc);
		instrWordT w;
		w = instrWordT'(golden[rowIdx(pc)]);
		if (w.jView.opcode == OpJ || w.jView.opcode == OpCall)
			return {4'b0, w.jView.target, 2'b00};
		return pc + 32'd4;
	endfunction

	function automatic int walkTrace();
		logic [31:0] pc;
		instrWordT w;
		int n;
		pc = '0;
		n = 0;
		do begin
			w = instrWordT'(golden[rowIdx(pc)]);
			pc = nextPc(pc);
			n++;
		end while (w.jView.opcode != OpExit && n < ProgWords);
		return n;
	endfunction

	task automatic checkWord(input string name, input logic [31:0] act, input logic [31:0] exp);
		if (act !== exp) begin
			$display("FAILED %s expected %h got %h at %0t", name, exp, act, $time);
			errors++;
		end
	endtask

	task automatic checkField(input string name, input logic [4:0] act, input logic [4:0] exp);
		if (act !== exp) begin
			$display("FAILED %s expected %h got %h at %0t", name, exp, act, $time);
			errors++;
		end
	endtask

	task automatic checkAluOp(input string name, input logic [3:0] act, input logic [3:0] exp);
		if (act !== exp) begin
			$display("FAILED %s expected %h got %h at %0t", name, exp, act, $time);
			errors++;
		end
	endtask

	task automatic checkFlags(input string name, input logic [10:0] act, input logic [10:0] exp);
		if (act !== exp) begin
			$display("FAILED %s expected %h got %h at %0t", name, exp, act, $time);
			errors++;
		end
	endtask

	task automatic checkMask(input string name, input warpMaskT act, input warpMaskT exp);
		if (act !== exp) begin
			$display("FAILED %s expected %h got %h at %0t", name, exp, act, $time);
			errors++;
		end
	endtask

	task automatic stepCycle();
		@(posedge clk);
		#2;
	endtask

	task automatic waitReset();
		int n;
		n = 0;
		while (!arstN && n < 50) begin
			@(posedge clk);
			n++;
		end
		if (!arstN) begin
			$display("reset still asserted after 50 cycles");
			timeouts++;
		end
		stepCycle();
	endtask

	// Setup cycle then access cycle, sampled mid-cycle
	task automatic apbXfer(input logic write, input logic [11:0] addr, input logic [31:0] data,
			output logic [31:0] rd, output logic slvErr);
		int n;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = data;
		stepCycle();
		penable = 1'b1;
		n = 0;
		@(negedge clk);
		while (!pready && n < WaitLimit) begin
			@(negedge clk);
			n++;
		end
		if (!pready) begin
			$display("no pready for address %h within %0d cycles", addr, WaitLimit);
			timeouts++;
		end
		rd = prdata;
		slvErr = pslverr;
		stepCycle();
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data, input logic expErr);
		logic [31:0] rd;
		logic slvErr;
		apbXfer(1'b1, addr, data, rd, slvErr);
		checkWord($sformatf("pslverr (write %h)", addr), 32'(slvErr), 32'(expErr));
	endtask

	task automatic apbRead(input logic [11:0] addr, input logic [31:0] exp);
		logic [31:0] rd;
		logic slvErr;
		apbXfer(1'b0, addr, 32'h0, rd, slvErr);
		checkWord($sformatf("prdata (read %h)", addr), rd, exp);
		checkWord($sformatf("pslverr (read %h)", addr), 32'(slvErr), 32'h0);
	endtask

	task automatic resetModel(input warpMaskT mask);
		for (int w = 0; w < NumWarps; w++) begin
			modelPc[w] = '0;
			issued[w] = 0;
		end
		exited = '0;
		launched = mask;
	endtask

	// One accepted issue, checked against the warp's own model
	task automatic checkIssue();
		int w;
		int row;
		instrWordT iw;
		string tag;
		w = 0;
		for (int i = NumWarps - 1; i >= 0; i--) begin
			if (issueWarp[i])
				w = i;
		end
		checkMask("issueWarp", issueWarp, warpMaskT'(1) << w);
		tag = $sformatf("warp %0d", w);
		if (!launched[w]) begin
			$display("issue from warp %0d which was never launched", w);
			errors++;
		end else if (exited[w]) begin
			$display("warp %0d issued again after its EXIT", w);
			errors++;
		end else begin
			row = rowIdx(modelPc[w]);
			iw = instrWordT'(golden[row]);
			checkWord({"issuePc ", tag}, issuePc, modelPc[w]);
			checkAluOp({"issueAluOp ", tag}, issueAluOp, golden[row + 1][3:0]);
			checkField({"issueDst ", tag}, issueDst, golden[row + 2][4:0]);
			checkFlags({"issueFlags ", tag}, issueFlags, golden[row + 3][10:0]);
			checkField({"issueSrc1 ", tag}, issueSrc1, iw.rView.rs);
			checkField({"issueSrc2 ", tag}, issueSrc2, iw.rView.rt);
			checkWord({"issueImme ", tag}, 32'(issueImme), 32'(iw.iView.imme));
			issued[w]++;
			if (iw.jView.opcode == OpExit)
				exited[w] = 1'b1;
			modelPc[w] = nextPc(modelPc[w]);
		end
	endtask

	task automatic waitAllExit(input string phase);
		int n;
		n = 0;
		while (exited != launched && n < RunLimit) begin
			@(posedge clk);
			n++;
		end
		stepCycle();
		if (exited != launched) begin
			$display("%s: not every launched warp reached EXIT within %0d cycles", phase, RunLimit);
			timeouts++;
		end
		for (int w = 0; w < NumWarps; w++) begin
			if (launched[w] && issued[w] != traceLen) begin
				$display("%s: warp %0d issued %0d instructions, trace has %0d", phase, w,
					issued[w], traceLen);
				errors++;
			end
		end
	endtask

	initial begin
		forever begin
			@(negedge clk);
			if (arstN && issueValid && issueReady)
				checkIssue();
		end
	end

	// Back-pressure source
	initial begin
		issueReady = 1'b1;
		forever begin
			@(posedge clk);
			#2;
			if (stallOn)
				issueReady = ($urandom % 100) >= golden[3];
			else
				issueReady = 1'b1;
		end
	end

	initial begin
		errors = 0;
		timeouts = 0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		stallOn = 1'b0;
		void'($urandom(Seed));
		$readmemh("sim/frontEndGolden.txt", golden);
		traceLen = walkTrace();
		resetModel('0);
		waitReset();

		for (int i = 0; i < ProgWords; i++)
			apbWrite(ApbImemBase + 12'(4 * i), golden[4 + 4 * i], 1'b0);
		apbWrite(12'h200, 32'hDEAD_BEEF, 1'b1); // Outside the map

		resetModel(golden[0][NumWarps-1:0]);
		apbWrite(ApbLaunchAddr, golden[0], 1'b0);
		apbRead(ApbStatusAddr, golden[0]);
		waitAllExit("single warp");
		apbRead(ApbStatusAddr, 32'h0);

		resetModel(golden[1][NumWarps-1:0]);
		stallOn = 1'b1;
		apbWrite(ApbLaunchAddr, golden[1], 1'b0);
		apbRead(ApbStatusAddr, golden[1]);
		apbWrite(ApbLaunchAddr, golden[2], 1'b1); // Warp still running
		waitAllExit("all warps");
		stallOn = 1'b0;
		apbRead(ApbStatusAddr, 32'h0);

		$display("errors %0d timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
verilog/gpuPkg.sv
verilog/fetchBus.sv
verilog/decodedBus.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/ibufStage.sv
verilog/gpuFrontEnd.sv
sim/clkGen.sv
sim/tbGpuFrontEnd.sv

//--- verilog/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage import gpuPkg::*; (
	input logic clk,
	input logic arstN,
	fetchBus.decode fb,
	decodedBus.source db
);

	instrWordT iw;
	logic [5:0] op;
	logic isInt;
	logic isImm;
	logic isLoad;
	logic isStore;
	logic isShared;
	logic isBeq;
	logic isBlt;
	logic isJump;
	logic isExit;
	logic isNoop;
	logic [3:0] aluOp;
	logic [31:0] nextPc;

	// Matches both the plain and the .S form
	function automatic logic opMatch(input logic [5:0] code, input logic [5:0] base);
		return {code[5], code[3:0]} == {base[5], base[3:0]};
	endfunction

	assign iw = fb.instr;
	assign op = iw.rView.opcode;

	assign isInt = opMatch(op, OpInt);
	assign isImm = opMatch(op, OpAddi) || opMatch(op, OpAndi) ||
		opMatch(op, OpOri) || opMatch(op, OpXori);
	assign isLoad = opMatch(op, OpLd) || opMatch(op, OpLds);
	assign isStore = opMatch(op, OpSw) || opMatch(op, OpSws);
	assign isShared = opMatch(op, OpLds) || opMatch(op, OpSws);
	assign isBeq = opMatch(op, OpBeq);
	assign isBlt = opMatch(op, OpBlt);
	assign isJump = opMatch(op, OpJ) || op == OpCall; // CALL has no .S form
	assign isExit = op == OpExit;
	assign isNoop = opMatch(op, OpNoop);

	// RET, BEQ and BLT fall through
	assign nextPc = isJump ? {4'b0, iw.jView.target, 2'b00} : fb.pc + 32'd4;

	always_comb begin
		aluOp = AluAdd;
		if (isImm) begin
			if (opMatch(op, OpAndi))
				aluOp = AluAnd;
			else if (opMatch(op, OpOri))
				aluOp = AluOr;
			else if (opMatch(op, OpXori))
				aluOp = AluXor;
		end else begin
			case (iw.rView.funct)
				FnAdd: aluOp = AluAdd;
				FnSub: aluOp = AluSub;
				FnMul: aluOp = AluMul;
				FnAnd: aluOp = AluAnd;
				FnOr: aluOp = AluOr;
				FnXor: aluOp = AluXor;
				FnShr: aluOp = AluShr;
				FnShl: aluOp = AluShl;
				default: aluOp = AluAdd;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			db.valid <= 1'b0;
		else
			db.valid <= fb.valid;
	end

	always_ff @(posedge clk) begin
		db.warp <= fb.warp;
		db.pc <= fb.pc;
		db.aluOp <= aluOp;
		db.src1 <= iw.rView.rs;
		db.src2 <= iw.rView.rt;
		db.dst <= (isLoad || isImm) ? iw.iView.rt : iw.rView.rd;
		db.imme <= iw.iView.imme;
		db.src1Valid <= isInt || isImm || isLoad || isStore || isBeq || isBlt;
		db.src2Valid <= isInt || isStore || isBeq || isBlt;
		db.immeValid <= isImm;
		db.regWrite <= isInt || isImm || isLoad;
		db.memRead <= isLoad;
		db.memWrite <= isStore;
		db.shared <= isShared;
		db.beq <= isBeq;
		db.blt <= isBlt;
		db.exit <= isExit;
		db.noop <= isNoop;
		fb.redirTarget <= nextPc;
	end

	// Feedback to fetch in the same cycle as the decoded entry
	assign fb.redirValid = db.valid;
	assign fb.redirWarp = db.warp;
	assign fb.exitValid = db.valid && db.exit;
	assign fb.exitWarp = db.warp;

	assert property (@(posedge clk) disable iff (!arstN)
		db.valid && db.immeValid |-> !db.memRead);

endmodule

`default_nettype wire

//--- verilog/decodedBus.sv
`timescale 1ns/10ps
`default_nettype none

interface decodedBus import gpuPkg::*; ();
	logic valid;
	warpMaskT warp;
	logic [31:0] pc;
	logic [3:0] aluOp;
	logic [4:0] src1;
	logic [4:0] src2;
	logic [4:0] dst;
	logic [15:0] imme;
	logic src1Valid;
	logic src2Valid;
	logic immeValid;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic shared; // LDS and SWS
	logic beq;
	logic blt;
	logic exit;
	logic noop;

	modport source (
		output valid, warp, pc, aluOp, src1, src2, dst, imme, src1Valid, src2Valid,
		output immeValid, regWrite, memRead, memWrite, shared, beq, blt, exit, noop
	);

	modport sink (
		input valid, warp, pc, aluOp, src1, src2, dst, imme, src1Valid, src2Valid,
		input immeValid, regWrite, memRead, memWrite, shared, beq, blt, exit, noop
	);
endinterface

`default_nettype wire

//--- verilog/fetchBus.sv
`timescale 1ns/10ps
`default_nettype none

interface fetchBus import gpuPkg::*; ();
	logic valid;
	warpMaskT warp;
	logic [31:0] pc;
	instrWordT instr;
	logic redirValid; // Next PC of the decoded warp
	warpMaskT redirWarp;
	logic [31:0] redirTarget;
	logic exitValid;
	warpMaskT exitWarp;

	modport fetch (
		output valid, warp, pc, instr,
		input redirValid, redirWarp, redirTarget, exitValid, exitWarp
	);

	modport decode (
		input valid, warp, pc, instr,
		output redirValid, redirWarp, redirTarget, exitValid, exitWarp
	);
endinterface

`default_nettype wire

//--- verilog/fetchStage.sv
`timescale 1ns/10ps
`default_nettype none

module fetchStage import gpuPkg::*; #(
	parameter int ImemDepth = 64
) (
	input logic clk,
	input logic arstN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [11:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input warpMaskT retireWarp,
	fetchBus.fetch fb
);

	localparam int AddrW = $clog2(ImemDepth);

	logic [31:0] imem [ImemDepth];
	logic [31:0] pcTable [NumWarps];
	warpMaskT active;
	warpMaskT busy;
	warpMaskT eligible;
	warpMaskT redirMask;
	warpMaskT exitMask;
	warpMaskT launchMask;
	warpMaskT pick;
	logic [WarpIdxW-1:0] pickIdx;
	logic [WarpIdxW-1:0] rrPtr;
	logic access;
	logic [11:0] imemOff;
	logic imemHit;
	logic launchHit;
	logic statusHit;
	logic launchErr;

	// APB slave, zero wait states
	assign access = psel && penable;
	assign imemOff = paddr - ApbImemBase;
	assign imemHit = imemOff < 12'(ImemDepth * 4);
	assign launchHit = paddr == ApbLaunchAddr;
	assign statusHit = paddr == ApbStatusAddr;
	assign launchErr = access && pwrite && launchHit && |(pwdata[NumWarps-1:0] & active);
	assign launchMask = (access && pwrite && launchHit && !launchErr) ?
		pwdata[NumWarps-1:0] : '0;
	assign pready = 1'b1;
	assign pslverr = access && (!(imemHit || launchHit || statusHit) || launchErr);
	assign prdata = (access && !pwrite && statusHit) ? 32'(active) : '0;

	assign redirMask = fb.redirValid ? fb.redirWarp : '0;
	assign exitMask = fb.exitValid ? fb.exitWarp : '0;
	assign eligible = active & ~busy & ~redirMask;

	// Round robin starting at rrPtr
	always_comb begin
		logic [WarpIdxW-1:0] candIdx;
		pick = '0;
		pickIdx = '0;
		for (int i = 0; i < NumWarps; i++) begin
			candIdx = rrPtr + WarpIdxW'(i);
			if (pick == '0 && eligible[candIdx]) begin
				pick[candIdx] = 1'b1;
				pickIdx = candIdx;
			end
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			active <= '0;
			busy <= '0;
			rrPtr <= '0;
			fb.valid <= 1'b0;
			fb.warp <= '0;
		end else begin
			active <= (active & ~exitMask) | launchMask;
			busy <= (busy | pick) & ~retireWarp;
			if (pick != '0)
				rrPtr <= pickIdx + 1'b1;
			fb.valid <= pick != '0;
			fb.warp <= pick;
		end
	end

	always_ff @(posedge clk) begin
		if (access && pwrite && imemHit)
			imem[imemOff[AddrW+1:2]] <= pwdata;
		for (int w = 0; w < NumWarps; w++) begin
			if (launchMask[w])
				pcTable[w] <= '0; // Launch wins over a late redirect
			else if (redirMask[w])
				pcTable[w] <= fb.redirTarget;
		end
		fb.pc <= pcTable[pickIdx];
		fb.instr <= imem[pcTable[pickIdx][AddrW+1:2]];
	end

	// At most one warp picked per cycle
	assert property (@(posedge clk) disable iff (!arstN)
		$onehot0(pick));

endmodule

`default_nettype wire

//--- verilog/gpuFrontEnd.sv
`timescale 1ns/10ps
`default_nettype none

module gpuFrontEnd import gpuPkg::*; #(
	parameter int ImemDepth = 64
) (
	input logic clk,
	input logic arstN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [11:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic issueReady,
	output logic issueValid,
	output warpMaskT issueWarp,
	output logic [31:0] issuePc,
	output logic [3:0] issueAluOp,
	output logic [4:0] issueSrc1,
	output logic [4:0] issueSrc2,
	output logic [4:0] issueDst,
	output logic [15:0] issueImme,
	output logic [10:0] issueFlags
);

	warpMaskT retireWarp; // Issued warps back to fetch

	fetchBus fbus ();
	decodedBus dbus ();

	fetchStage #(
		.ImemDepth(ImemDepth)
	) u_fetchStage (
		.clk(clk),
		.arstN(arstN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.retireWarp(retireWarp),
		.fb(fbus.fetch)
	);

	decodeStage u_decodeStage (
		.clk(clk),
		.arstN(arstN),
		.fb(fbus.decode),
		.db(dbus.source)
	);

	ibufStage u_ibufStage (
		.clk(clk),
		.arstN(arstN),
		.issueReady(issueReady),
		.db(dbus.sink),
		.issueValid(issueValid),
		.retireWarp(retireWarp),
		.issueWarp(issueWarp),
		.issuePc(issuePc),
		.issueAluOp(issueAluOp),
		.issueSrc1(issueSrc1),
		.issueSrc2(issueSrc2),
		.issueDst(issueDst),
		.issueImme(issueImme),
		.issueFlags(issueFlags)
	);

endmodule

`default_nettype wire

//--- verilog/gpuPkg.sv
`default_nettype none

package gpuPkg;

	localparam int NumWarps = 8;
	localparam int WarpIdxW = $clog2(NumWarps);

	typedef logic [NumWarps-1:0] warpMaskT; // One-hot warp id

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rViewT;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imme;
	} iViewT;

	typedef struct packed {
		logic [5:0] opcode;
		logic [25:0] target;
	} jViewT;

	typedef union packed {
		rViewT rView;
		iViewT iView;
		jViewT jView;
	} instrWordT;

	// Base encodings, bit 4 is the .S flag
	localparam logic [5:0] OpInt = 6'b000000;
	localparam logic [5:0] OpNoop = 6'b000001;
	localparam logic [5:0] OpJ = 6'b000010;
	localparam logic [5:0] OpCall = 6'b000011;
	localparam logic [5:0] OpBeq = 6'b000100;
	localparam logic [5:0] OpRet = 6'b000110;
	localparam logic [5:0] OpBlt = 6'b000111;
	localparam logic [5:0] OpAddi = 6'b001000;
	localparam logic [5:0] OpAndi = 6'b001100;
	localparam logic [5:0] OpOri = 6'b001101;
	localparam logic [5:0] OpXori = 6'b001110;
	localparam logic [5:0] OpExit = 6'b100001;
	localparam logic [5:0] OpLd = 6'b100011;
	localparam logic [5:0] OpLds = 6'b100111;
	localparam logic [5:0] OpSw = 6'b101011;
	localparam logic [5:0] OpSws = 6'b101111;

	// Funct field of integer ops
	localparam logic [5:0] FnAdd = 6'b100000;
	localparam logic [5:0] FnSub = 6'b100010;
	localparam logic [5:0] FnMul = 6'b011000;
	localparam logic [5:0] FnAnd = 6'b100100;
	localparam logic [5:0] FnOr = 6'b100101;
	localparam logic [5:0] FnXor = 6'b100110;
	localparam logic [5:0] FnShr = 6'b000010;
	localparam logic [5:0] FnShl = 6'b000000;

	localparam logic [3:0] AluAdd = 4'd0;
	localparam logic [3:0] AluSub = 4'd1;
	localparam logic [3:0] AluMul = 4'd2;
	localparam logic [3:0] AluAnd = 4'd3;
	localparam logic [3:0] AluOr = 4'd4;
	localparam logic [3:0] AluXor = 4'd5;
	localparam logic [3:0] AluShr = 4'd6;
	localparam logic [3:0] AluShl = 4'd7;

	localparam logic [11:0] ApbImemBase = 12'h000;
	localparam logic [11:0] ApbLaunchAddr = 12'h100;
	localparam logic [11:0] ApbStatusAddr = 12'h104;

endpackage

`default_nettype wire

//--- verilog/ibufStage.sv
`timescale 1ns/10ps
`default_nettype none

module ibufStage import gpuPkg::*; (
	input logic clk,
	input logic arstN,
	input logic issueReady,
	decodedBus.sink db,
	output logic issueValid,
	output warpMaskT retireWarp,
	output warpMaskT issueWarp,
	output logic [31:0] issuePc,
	output logic [3:0] issueAluOp,
	output logic [4:0] issueSrc1,
	output logic [4:0] issueSrc2,
	output logic [4:0] issueDst,
	output logic [15:0] issueImme,
	output logic [10:0] issueFlags
);

	localparam int EntryW = 32 + 4 + 5 + 5 + 5 + 16 + 11;

	logic [EntryW-1:0] slot [NumWarps];
	logic [EntryW-1:0] wrEntry;
	warpMaskT slotFull;
	warpMaskT writeMask;
	logic [WarpIdxW-1:0] issueIdx;

	assign wrEntry = {db.pc, db.aluOp, db.src1, db.src2, db.dst, db.imme,
		db.src1Valid, db.src2Valid, db.immeValid, db.regWrite, db.memRead,
		db.memWrite, db.shared, db.beq, db.blt, db.exit, db.noop};
	assign writeMask = db.valid ? db.warp : '0;

	// Lowest full slot wins
	always_comb begin
		issueIdx = '0;
		for (int w = NumWarps - 1; w >= 0; w--) begin
			if (slotFull[w])
				issueIdx = WarpIdxW'(w);
		end
	end

	assign issueValid = slotFull != '0;

	always_comb begin
		issueWarp = '0;
		if (issueValid)
			issueWarp[issueIdx] = 1'b1;
	end

	assign {issuePc, issueAluOp, issueSrc1, issueSrc2, issueDst, issueImme,
		issueFlags} = slot[issueIdx];
	assign retireWarp = (issueValid && issueReady) ? issueWarp : '0;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			slotFull <= '0;
		else
			slotFull <= (slotFull | writeMask) & ~retireWarp;
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < NumWarps; w++) begin
			if (writeMask[w])
				slot[w] <= wrEntry;
		end
	end

	// Fetch busy bits must keep a warp out until its slot drains
	assert property (@(posedge clk) disable iff (!arstN)
		(writeMask & slotFull) == '0);

endmodule

`default_nettype wire
